// ==== rtl/opl_cfg_pkg.sv ====
// Slot and word geometry of the operator store. A slot index is 5 bits wide, so LEN must stay at or below 32.
package opl_cfg_pkg;

    localparam int default_len = 18; // an OPL2 style channel set holds eighteen operator slots.
    localparam int default_div = 4;  // four clocks pass between two slot enables by default.

    localparam int slot_w = 5;  // wide enough to count up to thirty-two slots.
    localparam int word_w = 32; // four byte fields make up one operator word.

    // slot_num_t names one operator slot in the rotation.
    typedef logic [slot_w-1:0] slot_num_t;

    // op_word_t is the packed operator word as it sits in the shift chain.
    typedef logic [word_w-1:0] op_word_t;

endpackage

// ==== rtl/opl_reg_pkg.sv ====
// Host register map of the operator store. Only four byte fields exist and the upper address bits are not decoded.
package opl_reg_pkg;

    localparam int axil_addr_w = 10; // the whole map fits in one kilobyte of address space.
    localparam int axil_data_w = 32; // the bus carries full words even though writes use one byte.

    typedef logic [7:0]               reg_byte_t;  // one register field as the host writes it.
    typedef logic [axil_addr_w-1:0]   axil_addr_t; // byte address on the host bus.
    typedef logic [axil_data_w-1:0]   axil_data_t; // write and read data on the host bus.
    typedef logic [axil_data_w/8-1:0] axil_strb_t; // byte strobes that come with the write data.
    typedef logic [1:0]               axil_resp_t; // response code on the B and R channels.

    // each field owns one byte lane of the operator word, counted from the top lane down.
    typedef enum logic [1:0] {
        fld_mult   = 2'd0, // lane 31:24 holds AM, VIB, EG type, KSR and MULT.
        fld_ksl_tl = 2'd1, // lane 23:16 holds key scale level and total level.
        fld_ar_dr  = 2'd2, // lane 15:8 holds attack and decay rate.
        fld_sl_rr  = 2'd3  // lane 7:0 holds sustain level and release rate.
    } field_e;

    // bit positions of the field and the slot inside a host address.
    localparam int addr_fld_lsb  = 8;
    localparam int addr_fld_msb  = 9;
    localparam int addr_slot_lsb = 2; // slots are word aligned so bits 1:0 carry nothing.
    localparam int addr_slot_msb = 6;

    localparam axil_resp_t resp_okay   = 2'b00; // the access reached a real slot.
    localparam axil_resp_t resp_slverr = 2'b10; // the slot lies past the last one in use.

endpackage

// ==== rtl/opl_upd_if.sv ====
// One byte-lane update toward the operator register. The update only takes effect on a cycle where cen is high.
`timescale 1ns/10ps

interface opl_upd_if
    import opl_reg_pkg::*;
();

    reg_byte_t din;       // new value for the selected byte lane.
    field_e    field;     // selects which lane of the word takes din.
    logic      update_op; // high for one clock on the enable of the target slot.
    logic      cen;       // slot enable that also moves the shift chain.

    // the host port drives the update and watches the enable.
    modport source (
        output din,
        output field,
        output update_op,
        input  cen
    );

    // the circular register only listens.
    modport sink (
        input  din,
        input  field,
        input  update_op,
        input  cen
    );

endinterface

// ==== rtl/opl_sh_rst.sv ====
// Word-wide shift chain that moves only on cen. Every stage clears on reset, so the store starts as all zero words.
`timescale 1ns/10ps

module opl_sh_rst
    import opl_cfg_pkg::*;
#(
    parameter int width  = $bits(op_word_t), // bits per stage.
    parameter int stages = default_len       // one stage per operator slot.
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             cen,
    input  logic [width-1:0] din,
    output logic [width-1:0] drop
);

    logic [width-1:0] chain [stages]; // chain[0] takes din and the last stage falls out.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < stages; i++) begin
                chain[i] <= '0; // each slot holds a zero word after reset.
            end
        end else if (cen) begin
            chain[0] <= din; // the new word enters at the head.
            for (int i = 1; i < stages; i++) begin
                chain[i] <= chain[i-1]; // all other words move one stage on.
            end
        end
    end

    assign drop = chain[stages-1]; // the oldest word leaves on the next enable.

endmodule

// ==== rtl/opl_csr.sv ====
// Circular operator register with a byte-lane input mux. Only one whole byte lane changes per update.
`timescale 1ns/10ps

module opl_csr
    import opl_cfg_pkg::*;
    import opl_reg_pkg::*;
#(
    parameter int LEN = default_len // number of slots and so number of chain stages.
) (
    input  logic     clk,
    input  logic     arst_n,
    opl_upd_if.sink  upd,
    output op_word_t shift_out
);

    op_word_t regop_in; // word that enters the chain on the next enable.

    // the chain output feeds back to its input so each word comes round every LEN enables.
    opl_sh_rst #(
        .width  ( $bits(op_word_t) ),
        .stages ( LEN              )
    ) u_regch (
        .clk    ( clk       ),
        .arst_n ( arst_n    ),
        .cen    ( upd.cen   ),
        .din    ( regop_in  ),
        .drop   ( shift_out )
    );

    // the selected lane takes the host byte and the other three lanes recirculate.
    always_comb begin
        regop_in = shift_out; // by default the word goes round unchanged.
        if (upd.update_op) begin
            case (upd.field)
                fld_mult: begin
                    regop_in[31:24] = upd.din; // AM, VIB, EG type, KSR and MULT.
                end
                fld_ksl_tl: begin
                    regop_in[23:16] = upd.din; // KSL and TL.
                end
                fld_ar_dr: begin
                    regop_in[15:8] = upd.din; // attack and decay rate.
                end
                fld_sl_rr: begin
                    regop_in[7:0] = upd.din; // sustain level and release rate.
                end
                default: begin
                    regop_in = shift_out; // an unknown field leaves the word alone.
                end
            endcase
        end
    end

endmodule

// ==== rtl/opl_slot_seq.sv ====
// Clock-enable divider and slot counter. DIV must be at least 1 and LEN at most 32.
`timescale 1ns/10ps

module opl_slot_seq
    import opl_cfg_pkg::*;
#(
    parameter int LEN = default_len, // slots per rotation.
    parameter int DIV = default_div  // clocks per slot enable.
) (
    input  logic      clk,
    input  logic      arst_n,
    output logic      cen,
    output slot_num_t slot_cnt
);

    localparam int               div_w     = (DIV > 1) ? $clog2(DIV) : 1;
    localparam logic [div_w-1:0] div_last  = div_w'(DIV - 1);  // final count before an enable.
    localparam slot_num_t        slot_last = slot_num_t'(LEN - 1); // last slot before the wrap.

    logic [div_w-1:0] div_cnt; // clocks since the last enable.

    // the divider fires cen for one clock out of every DIV.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            cen     <= 1'b0;
        end else begin
            cen <= (div_cnt == div_last); // registered so cen is a clean one clock pulse.
            if (div_cnt == div_last) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // slot_cnt names the word at the chain output while cen is high.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_cnt <= '0; // slot zero sits at the output after reset.
        end else if (cen) begin
            if (slot_cnt == slot_last) begin
                slot_cnt <= '0; // one full rotation is done.
            end else begin
                slot_cnt <= slot_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/opl_axil_regs.sv ====
// AXI4-Lite slave for the operator store. One write and one read may be pending, wstrb is ignored and only wdata[7:0] is written.
`timescale 1ns/10ps

module opl_axil_regs
    import opl_cfg_pkg::*;
    import opl_reg_pkg::*;
#(
    parameter int LEN = default_len // slots at or above LEN answer with SLVERR.
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       awvalid,
    output logic       awready,
    input  axil_addr_t awaddr,
    input  logic       wvalid,
    output logic       wready,
    input  axil_data_t wdata,
    input  axil_strb_t wstrb,
    output logic       bvalid,
    input  logic       bready,
    output axil_resp_t bresp,
    input  logic       arvalid,
    output logic       arready,
    input  axil_addr_t araddr,
    output logic       rvalid,
    input  logic       rready,
    output axil_data_t rdata,
    output axil_resp_t rresp,
    input  slot_num_t  slot_cnt,
    input  op_word_t   shift_out,
    opl_upd_if.source  upd
);

    typedef enum logic [1:0] {w_idle, w_wait_slot, w_resp} wr_state_e;
    typedef enum logic [1:0] {r_idle, r_wait_slot, r_resp} rd_state_e;

    wr_state_e  wr_state;  // write channel FSM.
    rd_state_e  rd_state;  // read channel FSM.
    slot_num_t  wr_slot;   // slot of the pending write.
    field_e     wr_field;  // byte lane of the pending write.
    reg_byte_t  wr_byte;   // data of the pending write.
    slot_num_t  rd_slot;   // slot of the pending read.
    slot_num_t  aw_slot;   // slot decoded from the write address.
    slot_num_t  ar_slot;   // slot decoded from the read address.
    logic       aw_ok;
    logic       ar_ok;
    logic       wr_accept; // AW and W are taken together in this clock.
    logic       rd_accept;
    logic       wr_hit;    // the pending write slot is at the tap on this enable.
    logic       rd_hit;

    // both channels share one address decode.
    function automatic slot_num_t addr_slot(axil_addr_t addr);
        return addr[addr_slot_msb:addr_slot_lsb];
    endfunction

    function automatic field_e addr_field(axil_addr_t addr);
        return field_e'(addr[addr_fld_msb:addr_fld_lsb]);
    endfunction

    // both channels share one range check.
    function automatic logic slot_ok(slot_num_t slot);
        return (int'(slot) < LEN);
    endfunction

    assign aw_slot = addr_slot(awaddr);
    assign ar_slot = addr_slot(araddr);
    assign aw_ok   = slot_ok(aw_slot);
    assign ar_ok   = slot_ok(ar_slot);

    // a channel is ready only while nothing is pending on it.
    assign awready = (wr_state == w_idle);
    assign wready  = (wr_state == w_idle);
    assign arready = (rd_state == r_idle);
    assign bvalid  = (wr_state == w_resp);
    assign rvalid  = (rd_state == r_resp);

    assign wr_accept = awvalid && wvalid && awready && wready;
    assign rd_accept = arvalid && arready;
    assign wr_hit    = (wr_state == w_wait_slot) && upd.cen && (slot_cnt == wr_slot);
    assign rd_hit    = (rd_state == r_wait_slot) && upd.cen && (slot_cnt == rd_slot);

    assign upd.update_op = wr_hit; // the merge happens on the same enable as the match.
    assign upd.field     = wr_field;
    assign upd.din       = wr_byte;

    // write FSM waits for its slot, then holds B until the master takes it.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_state <= w_idle;
        end else begin
            case (wr_state)
                w_idle: begin
                    if (wr_accept) begin
                        wr_state <= aw_ok ? w_wait_slot : w_resp; // a bad slot answers at once.
                    end
                end
                w_wait_slot: begin
                    if (wr_hit) begin
                        wr_state <= w_resp; // bvalid rises the clock after update_op.
                    end
                end
                w_resp: begin
                    if (bready) begin
                        wr_state <= w_idle;
                    end
                end
                default: begin
                    wr_state <= w_idle;
                end
            endcase
        end
    end

    // read FSM waits for its slot to reach the tap, then holds R until taken.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_state <= r_idle;
        end else begin
            case (rd_state)
                r_idle: begin
                    if (rd_accept) begin
                        rd_state <= ar_ok ? r_wait_slot : r_resp;
                    end
                end
                r_wait_slot: begin
                    if (rd_hit) begin
                        rd_state <= r_resp;
                    end
                end
                r_resp: begin
                    if (rready) begin
                        rd_state <= r_idle;
                    end
                end
                default: begin
                    rd_state <= r_idle;
                end
            endcase
        end
    end

    // the write payload is captured at the accept and stays put until the response.
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            wr_slot  <= aw_slot;
            wr_field <= addr_field(awaddr);
            wr_byte  <= wdata[7:0];                    // the field is one byte wide.
            bresp    <= aw_ok ? resp_okay : resp_slverr; // known at accept time.
        end
    end

    // the read payload comes from the address check or from the tap.
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rd_slot <= ar_slot;
            if (!ar_ok) begin
                rdata <= '0; // an out of range read returns zero.
                rresp <= resp_slverr;
            end
        end
        if (rd_hit) begin
            rdata <= shift_out; // the word before any merge on this same enable.
            rresp <= resp_okay;
        end
    end

endmodule

// ==== rtl/opl_opreg_top.sv ====
// Top level of the operator register store. LEN must be at most 32 and DIV at least 1.
`timescale 1ns/10ps

module opl_opreg_top
    import opl_cfg_pkg::*;
    import opl_reg_pkg::*;
#(
    parameter int LEN = default_len, // operator slots in the ring.
    parameter int DIV = default_div  // clocks per slot enable.
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       awvalid,
    output logic       awready,
    input  axil_addr_t awaddr,
    input  logic       wvalid,
    output logic       wready,
    input  axil_data_t wdata,
    input  axil_strb_t wstrb,
    output logic       bvalid,
    input  logic       bready,
    output axil_resp_t bresp,
    input  logic       arvalid,
    output logic       arready,
    input  axil_addr_t araddr,
    output logic       rvalid,
    input  logic       rready,
    output axil_data_t rdata,
    output axil_resp_t rresp
);

    slot_num_t slot_cnt;  // slot whose word is at the tap.
    op_word_t  shift_out; // word at the tap.

    opl_upd_if upd (); // carries the update and the enable.

    // the sequencer drives the enable straight into the update bundle.
    opl_slot_seq #(
        .LEN ( LEN ),
        .DIV ( DIV )
    ) u_seq (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .cen      ( upd.cen  ),
        .slot_cnt ( slot_cnt )
    );

    opl_axil_regs #(
        .LEN ( LEN )
    ) u_host (
        .clk       ( clk        ),
        .arst_n    ( arst_n     ),
        .awvalid   ( awvalid    ),
        .awready   ( awready    ),
        .awaddr    ( awaddr     ),
        .wvalid    ( wvalid     ),
        .wready    ( wready     ),
        .wdata     ( wdata      ),
        .wstrb     ( wstrb      ),
        .bvalid    ( bvalid     ),
        .bready    ( bready     ),
        .bresp     ( bresp      ),
        .arvalid   ( arvalid    ),
        .arready   ( arready    ),
        .araddr    ( araddr     ),
        .rvalid    ( rvalid     ),
        .rready    ( rready     ),
        .rdata     ( rdata      ),
        .rresp     ( rresp      ),
        .slot_cnt  ( slot_cnt   ),
        .shift_out ( shift_out  ),
        .upd       ( upd.source )
    );

    opl_csr #(
        .LEN ( LEN )
    ) u_csr (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .upd       ( upd.sink  ),
        .shift_out ( shift_out )
    );

endmodule

// ==== verif/opl_opreg_tb.sv ====
// Runs LEN 18 and DIV 4 only. Accesses go one at a time, so a read never overlaps a write.
`timescale 1ns/10ps

module opl_opreg_tb
    import opl_cfg_pkg::*;
    import opl_reg_pkg::*;
();

    localparam int LEN      = 18;
    localparam int DIV      = 4;
    localparam int rot_clks = LEN * DIV;     // clocks in one full rotation of the ring.
    localparam int hs_limit = rot_clks + 20; // longest wait for any single handshake.

    typedef enum logic [1:0] {op_write, op_read, op_idle} op_kind_e;

    typedef struct packed {
        op_kind_e   kind;
        slot_num_t  slot;
        field_e     field;
        reg_byte_t  data;  // write byte, or rotations to wait for an idle entry.
        axil_resp_t resp;
    } entry_t;

    logic       clk;
    logic       arst_n;
    logic       awvalid, awready, wvalid, wready, bvalid, bready;
    logic       arvalid, arready, rvalid, rready;
    axil_addr_t awaddr, araddr;
    axil_data_t wdata, rdata;
    axil_strb_t wstrb;
    axil_resp_t bresp, rresp;

    entry_t   stim_q [$];   // the stimulus table.
    op_word_t model [LEN];  // expected word of every slot.
    int       word_errs = 0;
    int       resp_errs = 0;
    int       byte_errs = 0;
    int       hs_errs   = 0;
    int       cycles    = 0;
    int       cycle_limit = 0; // stays 0 until the table is built.

    opl_opreg_top #(.LEN(LEN), .DIV(DIV)) i_dut (
        .clk(clk), .arst_n(arst_n),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk; // 10 ns period.

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clocks.", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check_word(input op_word_t got, input op_word_t exp, input string what);
        if (got !== exp) begin
            word_errs++;
            $display("CHECK FAILED at %0t: %s, got %08h, expected %08h.", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(input axil_resp_t got, input axil_resp_t exp, input string what);
        if (got !== exp) begin
            resp_errs++;
            $display("CHECK FAILED at %0t: %s, got %02b, expected %02b.", $time, what, got, exp);
        end
    endtask

    task automatic check_byte(input reg_byte_t got, input reg_byte_t exp, input string what);
        if (got !== exp) begin
            byte_errs++;
            $display("CHECK FAILED at %0t: %s, got %02h, expected %02h.", $time, what, got, exp);
        end
    endtask

    // fld_mult is the top lane and each later field sits one byte lower.
    function automatic reg_byte_t lane_of(op_word_t word, field_e fld);
        return word[(3 - int'(fld)) * 8 +: 8];
    endfunction

    function automatic op_word_t merge_lane(op_word_t word, field_e fld, reg_byte_t data);
        op_word_t res;
        res = word;
        res[(3 - int'(fld)) * 8 +: 8] = data; // the other three lanes keep their value.
        return res;
    endfunction

    function automatic axil_addr_t make_addr(field_e fld, slot_num_t slot, logic [2:0] junk);
        axil_addr_t addr;
        addr = '0;
        addr[addr_fld_msb:addr_fld_lsb]   = fld;
        addr[addr_slot_msb:addr_slot_lsb] = slot;
        addr[7]   = junk[2];   // bits outside the map must not matter.
        addr[1:0] = junk[1:0];
        return addr;
    endfunction

    task automatic add_entry(input op_kind_e kind, input int slot, input field_e fld,
                             input reg_byte_t data);
        entry_t e;
        e.kind  = kind;
        e.slot  = slot_num_t'(slot);
        e.field = fld;
        e.data  = data;
        e.resp  = (slot < LEN) ? resp_okay : resp_slverr; // slots past the ring are refused.
        stim_q.push_back(e);
    endtask

    task automatic build_table();
        int sl;
        for (int s = 0; s < LEN; s++) begin
            add_entry(op_read, s, fld_mult, 8'h00); // every slot starts at zero.
        end
        for (int k = 0; k < 6; k++) begin
            sl = (k < 5) ? k * 4 : LEN - 1; // slots 0, 4, 8, 12, 16 and the last one.
            for (int f = 0; f < 4; f++) begin
                add_entry(op_write, sl, field_e'(f), 8'(sl * 11 + f * 53 + 7));
            end
            add_entry(op_read, sl, fld_mult, 8'h00);
        end
        add_entry(op_write, 4, fld_ar_dr, 8'h3c);  // one lane changes, three stay.
        add_entry(op_read, 3, fld_mult, 8'h00);
        add_entry(op_read, 4, fld_mult, 8'h00);
        add_entry(op_read, 5, fld_mult, 8'h00);
        add_entry(op_write, LEN - 1, fld_mult, 8'he1);
        add_entry(op_read, LEN - 1, fld_mult, 8'h00);
        add_entry(op_read, 0, fld_mult, 8'h00);
        add_entry(op_write, LEN, fld_mult, 8'hff);  // first slot past the ring.
        add_entry(op_write, 31, fld_sl_rr, 8'h5a);
        add_entry(op_read, LEN, fld_mult, 8'h00);
        add_entry(op_read, 25, fld_mult, 8'h00);
        add_entry(op_read, 31, fld_mult, 8'h00);
        add_entry(op_idle, 0, fld_mult, 8'd4);      // let the ring turn four more times.
        for (int s = 0; s < LEN; s++) begin
            add_entry(op_read, s, fld_mult, 8'h00);
        end
    endtask

    task automatic write_field(input entry_t e);
        int         waited;
        int         delay;
        axil_resp_t held;
        @(negedge clk);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = make_addr(e.field, e.slot, 3'($urandom));
        wdata   = {24'($urandom), e.data}; // only the low byte should land.
        wstrb   = 4'($urandom);
        waited  = 0;
        while (!(awready && wready) && waited < hs_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!(awready && wready)) begin
            $display("Write to slot %0d was never accepted on AW and W.", e.slot);
            hs_errs++;
        end
        @(negedge clk); // the accept falls on the rising edge in between.
        awvalid = 1'b0;
        wvalid  = 1'b0;
        waited  = 0;
        while (!bvalid && waited < hs_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!bvalid) begin
            $display("Write to slot %0d never got a response on B.", e.slot);
            hs_errs++;
            return;
        end
        check_resp(bresp, e.resp, $sformatf("bresp of write to slot %0d", e.slot));
        held  = bresp;
        delay = $urandom % 4;
        repeat (delay) begin
            @(negedge clk);
            if (!bvalid) begin
                $display("bvalid dropped before bready at %0t.", $time);
                hs_errs++;
            end
            check_resp(bresp, held, "bresp under back-pressure");
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        if (bvalid) begin
            $display("bvalid stayed high after the B handshake at %0t.", $time);
            hs_errs++;
        end
        if (e.resp == resp_okay) begin
            model[e.slot] = merge_lane(model[e.slot], e.field, e.data);
        end
    endtask

    task automatic read_word(input entry_t e);
        int         waited;
        int         delay;
        op_word_t   held;
        axil_resp_t held_resp;
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = make_addr(field_e'(2'($urandom)), e.slot, 3'($urandom)); // the field is unused.
        waited  = 0;
        while (!arready && waited < hs_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!arready) begin
            $display("Read of slot %0d was never accepted on AR.", e.slot);
            hs_errs++;
        end
        @(negedge clk);
        arvalid = 1'b0;
        waited  = 0;
        while (!rvalid && waited < hs_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!rvalid) begin
            $display("Read of slot %0d never got data on R.", e.slot);
            hs_errs++;
            return;
        end
        check_resp(rresp, e.resp, $sformatf("rresp of read from slot %0d", e.slot));
        if (e.resp == resp_okay) begin
            for (int f = 0; f < 4; f++) begin
                check_byte(lane_of(rdata, field_e'(f)), lane_of(model[e.slot], field_e'(f)),
                           $sformatf("lane %0d of slot %0d", f, e.slot));
            end
        end else begin
            check_word(rdata, '0, $sformatf("rdata of refused read from slot %0d", e.slot));
        end
        held      = rdata;
        held_resp = rresp;
        delay     = $urandom % 4;
        repeat (delay) begin
            @(negedge clk);
            if (!rvalid) begin
                $display("rvalid dropped before rready at %0t.", $time);
                hs_errs++;
            end
            check_word(rdata, held, "rdata under back-pressure");
            check_resp(rresp, held_resp, "rresp under back-pressure");
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
        if (rvalid) begin
            $display("rvalid stayed high after the R handshake at %0t.", $time);
            hs_errs++;
        end
    endtask

    initial begin
        int unsigned seed_ret;
        entry_t      e;
        seed_ret = $urandom(32'h9487_15d8);
        arst_n  = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        for (int s = 0; s < LEN; s++) begin
            model[s] = '0;
        end
        build_table();
        cycle_limit = stim_q.size() * (rot_clks + 10) * 2 + 50;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < stim_q.size(); i++) begin
            e = stim_q[i];
            case (e.kind)
                op_write: write_field(e);
                op_read:  read_word(e);
                default:  repeat (int'(e.data) * rot_clks) @(negedge clk);
            endcase
        end
        repeat (2) @(negedge clk);
        $display("Errors: word %0d, response %0d, byte %0d, handshake %0d.",
                 word_errs, resp_errs, byte_errs, hs_errs);
        if (word_errs + resp_errs + byte_errs + hs_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== opl_opreg.f ====
rtl/opl_cfg_pkg.sv
rtl/opl_reg_pkg.sv
rtl/opl_upd_if.sv
rtl/opl_sh_rst.sv
rtl/opl_csr.sv
rtl/opl_slot_seq.sv
rtl/opl_axil_regs.sv
rtl/opl_opreg_top.sv
verif/opl_opreg_tb.sv

// ==== Bender.yml ====
package:
  name: opl_opreg

sources:
  - rtl/opl_cfg_pkg.sv
  - rtl/opl_reg_pkg.sv
  - rtl/opl_upd_if.sv
  - rtl/opl_sh_rst.sv
  - rtl/opl_csr.sv
  - rtl/opl_slot_seq.sv
  - rtl/opl_axil_regs.sv
  - rtl/opl_opreg_top.sv
  - target: simulation
    files:
      - verif/opl_opreg_tb.sv
